// File: common/ssb_macros.svh
`ifndef SSB_MACROS_SVH
`define SSB_MACROS_SVH

// Interleaved I/Q drive input width
`define SSB_DRIVE_W 18
// Local oscillator word width (cosa, sina)
`define SSB_LO_W 18
// Interpolated baseband width, one bit above the drive slice
`define SSB_IQ_W 17
// DAC word width
`define SSB_DAC_W 16
// Midpoint correction coefficient, 32768 is a gain of one half
`define SSB_COEFF_W 16

// Pipeline depth of each stage in clk cycles
`define SSB_LAT_INTERP 2
`define SSB_LAT_MIX 2
`define SSB_LAT_AFTB 3

// Product scaling back to DAC range
`define SSB_MIX_SHIFT 17
`define SSB_AFTB_SHIFT 16

// Saturation input width and DAC limits
`define SSB_SAT_W 40
`define SSB_DAC_MAX 32767
`define SSB_DAC_MIN (-32768)

`endif

// File: common/ssb_pkg.sv
`include "ssb_macros.svh"

package ssb_pkg;

	// Raw drive sample, I and Q alternating
	typedef logic signed [`SSB_DRIVE_W-1:0] drive_t;

	// LO sample
	typedef logic signed [`SSB_LO_W-1:0] lo_t;

	// Full-rate I or Q after interpolation
	typedef logic signed [`SSB_IQ_W-1:0] iq_t;

	// Two's-complement DAC word
	typedef logic signed [`SSB_DAC_W-1:0] dac_t;

	// Unsigned gain, full scale just under unity
	typedef logic [`SSB_COEFF_W-1:0] coeff_t;

	// div_state bit 0, high while an I sample sits on the drive input
	typedef enum logic {
		PHASE_Q = 1'b0,
		PHASE_I = 1'b1
	} iq_phase_e;

	// Clamp a wide signed value into the DAC range
	function automatic dac_t sat_dac(input logic signed [`SSB_SAT_W-1:0] v);
		if (v > `SSB_DAC_MAX)
			return dac_t'(`SSB_DAC_MAX);
		else if (v < `SSB_DAC_MIN)
			return dac_t'(`SSB_DAC_MIN);
		else
			return dac_t'(v);
	endfunction

endpackage

// File: hdl/fiq_interp.sv
`timescale 1ns/1ps
`include "ssb_macros.svh"

module fiq_interp import ssb_pkg::*; (
	input  logic                        clk,
	input  logic                        i_arst_n,
	input  logic signed [`SSB_IQ_W-2:0] i_data,
	input  iq_phase_e                   i_phase,
	output iq_t                         o_i_data,
	output iq_t                         o_q_data
);

	// Per channel history, newest and the one before
	logic signed [`SSB_IQ_W-2:0] i_new, i_old;
	logic signed [`SSB_IQ_W-2:0] q_new, q_old;
	// Which channel was captured last cycle
	iq_phase_e phase_d;

	// Stage 1
	// Steer the incoming sample into its channel history
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			i_new   <= '0;
			i_old   <= '0;
			q_new   <= '0;
			q_old   <= '0;
			phase_d <= PHASE_Q;
		end else begin
			phase_d <= i_phase;
			if (i_phase == PHASE_I) begin
				i_old <= i_new;
				i_new <= i_data;
			end else begin
				q_old <= q_new;
				q_new <= i_data;
			end
		end
	end

	// Stage 2
	// Output is at twice the input scale, so the sum is the exact average
	// The channel just updated gives its midpoint, the other one repeats its newest sample
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_i_data <= '0;
			o_q_data <= '0;
		end else if (phase_d == PHASE_I) begin
			o_i_data <= iq_t'(i_old) + iq_t'(i_new);
			o_q_data <= {q_new, 1'b0};
		end else begin
			o_i_data <= {i_new, 1'b0};
			o_q_data <= iq_t'(q_old) + iq_t'(q_new);
		end
	end

endmodule

// File: hdl/flevel_set.sv
`timescale 1ns/1ps
`include "ssb_macros.svh"

module flevel_set import ssb_pkg::*; (
	input  logic clk,
	input  logic i_arst_n,
	input  lo_t  i_cosd,
	input  lo_t  i_sind,
	input  iq_t  i_i_data,
	input  iq_t  i_q_data,
	output dac_t o_data
);

	// Full precision products
	logic signed [`SSB_IQ_W+`SSB_LO_W-1:0] prod_i;
	logic signed [`SSB_IQ_W+`SSB_LO_W-1:0] prod_q;
	// One guard bit for the sum
	logic signed [`SSB_IQ_W+`SSB_LO_W:0] prod_sum;
	// Sum scaled back towards DAC range, before clamping
	logic signed [`SSB_SAT_W-1:0] mix_scaled;

	// Stage 1
	// I against cosine, Q against sine
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			prod_i <= '0;
			prod_q <= '0;
		end else begin
			prod_i <= i_i_data * i_cosd;
			prod_q <= i_q_data * i_sind;
		end
	end

	// Dot product
	assign prod_sum = prod_i + prod_q;

	// Arithmetic shift keeps the sign
	assign mix_scaled = prod_sum >>> `SSB_MIX_SHIFT;

	// Stage 2
	// Clamp to the DAC range
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n)
			o_data <= '0;
		else
			o_data <= sat_dac(mix_scaled);
	end

endmodule

// File: hdl/afterburner.sv
`timescale 1ns/1ps
`include "ssb_macros.svh"

module afterburner import ssb_pkg::*; (
	input  logic                        clk,
	input  logic                        i_arst_n,
	input  logic signed [`SSB_IQ_W-1:0] i_data,
	input  coeff_t                      i_coeff,
	output logic [`SSB_DAC_W-1:0]       o_data0,
	output logic [`SSB_DAC_W-1:0]       o_data1
);

	// Sample x[n] while x[n+1] is on the input
	logic signed [`SSB_IQ_W-1:0] x_d1;
	// Direct path, aligned with the pair sum
	logic signed [`SSB_IQ_W-1:0] dir_r;
	// x[n] + x[n+1]
	logic signed [`SSB_IQ_W:0] sum_r;
	// Coefficient widened with a zero sign bit
	logic signed [`SSB_COEFF_W:0] coeff_s;
	// Midpoint product and its scaled value
	logic signed [`SSB_IQ_W+`SSB_COEFF_W+1:0] mid_prod;
	logic signed [`SSB_SAT_W-1:0] mid_scaled;
	// Two's-complement results
	dac_t out0_r;
	dac_t out1_r;

	// Stage 1
	// One-sample delay gives the lookahead for the midpoint
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n)
			x_d1 <= '0;
		else
			x_d1 <= i_data;
	end

	// Stage 2
	// Pairwise sum of the held sample and the newest one
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			dir_r <= '0;
			sum_r <= '0;
		end else begin
			dir_r <= x_d1;
			sum_r <= x_d1 + i_data;
		end
	end

	assign coeff_s = {1'b0, i_coeff};

	// Linear interpolation droops at the midpoint
	// A coefficient above 32768 lifts it back up
	assign mid_prod   = sum_r * coeff_s;
	assign mid_scaled = mid_prod >>> `SSB_AFTB_SHIFT;

	// Stage 3
	// Both words clamped to the DAC range
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			out0_r <= '0;
			out1_r <= '0;
		end else begin
			out0_r <= sat_dac(dir_r);
			out1_r <= sat_dac(mid_scaled);
		end
	end

	// Offset binary for the DAC, sign bit inverted
	assign o_data0 = {~out0_r[`SSB_DAC_W-1], out0_r[`SSB_DAC_W-2:0]};
	assign o_data1 = {~out1_r[`SSB_DAC_W-1], out1_r[`SSB_DAC_W-2:0]};

endmodule

// File: ssb_out/ssb_out.sv
`timescale 1ns/1ps
`include "ssb_macros.svh"

module ssb_out import ssb_pkg::*; (
	input  logic       clk,
	input  logic       i_arst_n,
	// Bit 0 flags I on the drive input
	input  logic [1:0] i_div_state,
	// Baseband, I and Q interleaved
	input  drive_t     i_drive,
	// Outputs forced to zero when low
	input  logic       i_enable,
	// Inverts the dac2 pair
	input  logic       i_ssb_flip,
	// Midpoint gain correction, see afterburner
	input  coeff_t     i_aftb_coeff,
	// Local oscillator
	input  lo_t        i_cosa,
	input  lo_t        i_sina,
	// In-phase DDR pair
	output dac_t       o_dac1_out0,
	output dac_t       o_dac1_out1,
	// Quadrature DDR pair
	output dac_t       o_dac2_out0,
	output dac_t       o_dac2_out1
);

	iq_phase_e drive_phase;
	// Full-rate baseband
	iq_t drive_i, drive_q;
	iq_t drive_q_n;
	// Mixer outputs
	dac_t out1, out2;
	// After flip and enable
	dac_t outf2;
	dac_t outk1, outk2;
	// Enable and flip delayed to line up with the LO at the mixer input
	logic [`SSB_LAT_MIX-1:0] en_dly;
	logic [`SSB_LAT_MIX-1:0] flip_dly;
	// Afterburner inputs, one extra LSB
	logic signed [`SSB_IQ_W-1:0] aftb_in1, aftb_in2;
	// Offset binary from the afterburners
	logic [`SSB_DAC_W-1:0] dac1_ob0, dac1_ob1;
	logic [`SSB_DAC_W-1:0] dac2_ob0, dac2_ob1;

	assign drive_phase = iq_phase_e'(i_div_state[0]);

	// Top bits of the drive word, brought to full rate
	fiq_interp interp (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_data   (i_drive[`SSB_DRIVE_W-1 -: `SSB_IQ_W-1]),
		.i_phase  (drive_phase),
		.o_i_data (drive_i),
		.o_q_data (drive_q)
	);

	// Hartley modulator
	// In-phase word is I*cos + Q*sin
	flevel_set level1 (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_cosd   (i_cosa),
		.i_sind   (i_sina),
		.i_i_data (drive_i),
		.i_q_data (drive_q),
		.o_data   (out1)
	);

	// Drive rotated by 90 degrees, (-Q, I), for the quadrature word
	// Bitwise inversion stands in for negation, one LSB off
	assign drive_q_n = ~drive_q;

	flevel_set level2 (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_cosd   (i_cosa),
		.i_sind   (i_sina),
		.i_i_data (drive_q_n),
		.i_q_data (drive_i),
		.o_data   (out2)
	);

	// Match the mixer depth so enable and flip act together with the LO
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			en_dly   <= '0;
			flip_dly <= '0;
		end else begin
			en_dly   <= {en_dly[`SSB_LAT_MIX-2:0], i_enable};
			flip_dly <= {flip_dly[`SSB_LAT_MIX-2:0], i_ssb_flip};
		end
	end

	// Flip on the quadrature word only
	assign outf2 = flip_dly[`SSB_LAT_MIX-1] ? ~out2 : out2;

	// Enable gate on both channels
	assign outk1 = en_dly[`SSB_LAT_MIX-1] ? out1 : '0;
	assign outk2 = en_dly[`SSB_LAT_MIX-1] ? outf2 : '0;

	assign aftb_in1 = {outk1, 1'b0};
	assign aftb_in2 = {outk2, 1'b0};

	// DDR expansion for the double-rate DAC
	afterburner afterburner1 (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_data   (aftb_in1),
		.i_coeff  (i_aftb_coeff),
		.o_data0  (dac1_ob0),
		.o_data1  (dac1_ob1)
	);

	afterburner afterburner2 (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_data   (aftb_in2),
		.i_coeff  (i_aftb_coeff),
		.o_data0  (dac2_ob0),
		.o_data1  (dac2_ob1)
	);

	// Back to two's complement
	assign o_dac1_out0 = {~dac1_ob0[`SSB_DAC_W-1], dac1_ob0[`SSB_DAC_W-2:0]};
	assign o_dac1_out1 = {~dac1_ob1[`SSB_DAC_W-1], dac1_ob1[`SSB_DAC_W-2:0]};
	assign o_dac2_out0 = {~dac2_ob0[`SSB_DAC_W-1], dac2_ob0[`SSB_DAC_W-2:0]};
	assign o_dac2_out1 = {~dac2_ob1[`SSB_DAC_W-1], dac2_ob1[`SSB_DAC_W-2:0]};

endmodule

// File: test/ssb_out_properties.sv
`timescale 1ns/1ps
`include "ssb_macros.svh"

module ssb_out_properties import ssb_pkg::*; (
	input logic clk,
	input logic i_arst_n,
	input logic i_enable,
	input logic i_ssb_flip,
	// Internal in-phase mixer word and gate level
	input dac_t i_mix1,
	input logic i_en_gate,
	input dac_t i_dac1_out0,
	input dac_t i_dac1_out1,
	input dac_t i_dac2_out0,
	input dac_t i_dac2_out1
);

	logic all_zero;
	// In-phase mixer word after the gate, with the expander's extra LSB
	logic signed [`SSB_DAC_W:0] mix1_x2;
	// Direct dac1 word expected once it leaves the expander
	dac_t dir1_exp;

	assign all_zero = (i_dac1_out0 == '0) && (i_dac1_out1 == '0) &&
		(i_dac2_out0 == '0) && (i_dac2_out1 == '0);

	assign mix1_x2 = i_en_gate ? {i_mix1, 1'b0} : '0;

	assign dir1_exp = (mix1_x2 > `SSB_DAC_MAX) ? dac_t'(`SSB_DAC_MAX) :
		(mix1_x2 < `SSB_DAC_MIN) ? dac_t'(`SSB_DAC_MIN) : dac_t'(mix1_x2);

	// Reset leaves every output cleared
	a_reset_zero: assert property (@(posedge clk) $rose(i_arst_n) |-> all_zero)
		else $error("outputs not zero after reset release");

	// Enable low long enough flushes the gated pipeline
	a_enable_zero: assert property (@(posedge clk) disable iff (!i_arst_n)
		(!i_enable)[*5] |=> all_zero)
		else $error("outputs not zero with enable held low");

	a_no_x: assert property (@(posedge clk) disable iff (!i_arst_n)
		!$isunknown({i_dac1_out0, i_dac1_out1, i_dac2_out0, i_dac2_out1}))
		else $error("unknown bits on DAC outputs");

	// Direct dac1 word stays the unflipped mixer word while flip is active
	a_flip_dac1: assert property (@(posedge clk) disable iff (!i_arst_n)
		$past(i_ssb_flip, `SSB_LAT_MIX + `SSB_LAT_AFTB) |->
		(i_dac1_out0 == $past(dir1_exp, `SSB_LAT_AFTB)))
		else $error("flip disturbed the dac1 path");

endmodule

bind ssb_out ssb_out_properties props (
	.clk         (clk),
	.i_arst_n    (i_arst_n),
	.i_enable    (i_enable),
	.i_ssb_flip  (i_ssb_flip),
	.i_mix1      (out1),
	.i_en_gate   (en_dly[`SSB_LAT_MIX-1]),
	.i_dac1_out0 (o_dac1_out0),
	.i_dac1_out1 (o_dac1_out1),
	.i_dac2_out0 (o_dac2_out0),
	.i_dac2_out1 (o_dac2_out1)
);

// File: test/ssb_out_tb.sv
`timescale 1ns/1ps
`include "ssb_macros.svh"

module ssb_out_tb import ssb_pkg::*; ();

	localparam int MAXE = 2048;
	// Cycles spent by all tests, used by the watchdog
	localparam int TOTAL_CYCLES = 2 + 10 + 3 * 200 + 85 + 100;
	localparam int LAT_TOTAL = `SSB_LAT_INTERP + `SSB_LAT_MIX + `SSB_LAT_AFTB;

	logic clk;
	logic arst_n;
	logic [1:0] div_state;
	drive_t drive;
	logic enable;
	logic ssb_flip;
	coeff_t aftb_coeff;
	lo_t cosa, sina;
	dac_t dac1_out0, dac1_out1, dac2_out0, dac2_out1;

	// Input history indexed by the clock edge that samples it
	longint h_drv[MAXE];
	longint h_cos[MAXE];
	longint h_sin[MAXE];
	longint h_coeff[MAXE];
	bit h_ph[MAXE];
	bit h_en[MAXE];
	bit h_flip[MAXE];

	int edge_n;
	bit running;
	logic [1:0] div_cnt;
	string test_name;
	int errs, test_errs, tests_run, tests_failed;

	ssb_out UUT (
		.clk          (clk),
		.i_arst_n     (arst_n),
		.i_div_state  (div_state),
		.i_drive      (drive),
		.i_enable     (enable),
		.i_ssb_flip   (ssb_flip),
		.i_aftb_coeff (aftb_coeff),
		.i_cosa       (cosa),
		.i_sina       (sina),
		.o_dac1_out0  (dac1_out0),
		.o_dac1_out1  (dac1_out1),
		.o_dac2_out0  (dac2_out0),
		.o_dac2_out1  (dac2_out1)
	);

	always #20 clk = ~clk;

	// Edges before the first capture hold zero data
	function automatic bit in_range(input int k);
		return (k >= 1) && (k < MAXE);
	endfunction

	function automatic longint sat16(input longint v);
		if (v > 32767)
			return 32767;
		else if (v < -32768)
			return -32768;
		else
			return v;
	endfunction

	// Full-rate baseband after edge e, at twice the input scale
	function automatic longint interp_val(input int e, input bit want_i);
		bit arrived_i;
		longint d1, d2, d3;
		arrived_i = in_range(e - 1) ? h_ph[e - 1] : 1'b0;
		d1 = in_range(e - 1) ? h_drv[e - 1] : 0;
		d2 = in_range(e - 2) ? h_drv[e - 2] : 0;
		d3 = in_range(e - 3) ? h_drv[e - 3] : 0;
		// Channel just updated gives the midpoint sum, the other repeats
		if (arrived_i == want_i)
			return d1 + d3;
		else
			return 2 * d2;
	endfunction

	// Mixer word after edge e, LO taken one edge earlier
	function automatic longint mixer_val(input int e, input bit quad);
		longint oi, oq, c, s, acc;
		oi = interp_val(e - 2, 1'b1);
		oq = interp_val(e - 2, 1'b0);
		c = in_range(e - 1) ? h_cos[e - 1] : 0;
		s = in_range(e - 1) ? h_sin[e - 1] : 0;
		if (quad)
			acc = (-oq - 1) * c + oi * s;
		else
			acc = oi * c + oq * s;
		return sat16(acc >>> 17);
	endfunction

	// Enable gate and flip after edge e
	function automatic longint gated_val(input int e, input bit quad);
		longint m;
		if (!in_range(e - 1) || !h_en[e - 1])
			return 0;
		m = mixer_val(e, quad);
		if (quad && h_flip[e - 1])
			m = -m - 1;
		return m;
	endfunction

	// Expected DDR pair of one channel after edge n
	function automatic void expect_pair(input int n, input bit quad,
		output longint out0, output longint out1);
		longint x0, x1, k;
		x0 = 2 * gated_val(n - 3, quad);
		x1 = 2 * gated_val(n - 2, quad);
		k = in_range(n) ? h_coeff[n] : 0;
		out0 = sat16(x0);
		out1 = sat16(((x0 + x1) * k) >>> 16);
	endfunction

	task automatic check_value(input string what, input longint exp, input longint act);
		if (exp != act) begin
			$display("MISMATCH %s %s: expected %0d, actual %0d at edge %0d",
				test_name, what, exp, act, edge_n);
			errs++;
			test_errs++;
		end
	endtask

	// One clock of stimulus, recorded for the edge that samples it
	task automatic drive_cycle(input bit en, input bit flip, input drive_t d,
		input lo_t c, input lo_t s, input coeff_t k);
		int idx;
		@(posedge clk);
		edge_n++;
		idx = edge_n + 1;
		if (idx < MAXE) begin
			h_drv[idx] = longint'($signed(d[`SSB_DRIVE_W-1:2]));
			h_cos[idx] = longint'(c);
			h_sin[idx] = longint'(s);
			h_coeff[idx] = longint'(k);
			h_ph[idx] = div_cnt[0];
			h_en[idx] = en;
			h_flip[idx] = flip;
		end
		arst_n <= 1'b1;
		div_state <= div_cnt;
		div_cnt = div_cnt + 1'b1;
		drive <= d;
		cosa <= c;
		sina <= s;
		aftb_coeff <= k;
		enable <= en;
		ssb_flip <= flip;
		running = 1'b1;
	endtask

	task automatic random_cycle(input bit en, input bit flip);
		drive_cycle(en, flip, drive_t'($urandom), lo_t'($urandom), lo_t'($urandom),
			coeff_t'($urandom));
	endtask

	task automatic check_all_zero();
		check_value("dac1_out0 zero", 0, longint'(dac1_out0));
		check_value("dac1_out1 zero", 0, longint'(dac1_out1));
		check_value("dac2_out0 zero", 0, longint'(dac2_out0));
		check_value("dac2_out1 zero", 0, longint'(dac2_out1));
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errs = 0;
		tests_run++;
	endtask

	task automatic end_test();
		if (test_errs == 0) begin
			$display("%s: ok", test_name);
		end else begin
			$display("%s: FAILED with %0d errors", test_name, test_errs);
			tests_failed++;
		end
	endtask

	// Compare every cycle against the model, outputs settled at the falling edge
	always @(negedge clk) begin
		longint e0, e1;
		if (running) begin
			expect_pair(edge_n, 1'b0, e0, e1);
			check_value("dac1_out0", e0, longint'(dac1_out0));
			check_value("dac1_out1", e1, longint'(dac1_out1));
			expect_pair(edge_n, 1'b1, e0, e1);
			check_value("dac2_out0", e0, longint'(dac2_out0));
			check_value("dac2_out1", e1, longint'(dac2_out1));
		end
	end

	// Watchdog
	initial begin
		#((TOTAL_CYCLES + 100) * 40);
		$display("Timeout: the tests did not finish in time");
		$display("Some tests failed");
		$finish;
	end

	initial begin
		void'($urandom(34532));
		clk = 1'b0;
		arst_n = 1'b0;
		div_state = '0;
		drive = '0;
		enable = 1'b0;
		ssb_flip = 1'b0;
		aftb_coeff = '0;
		cosa = '0;
		sina = '0;
		div_cnt = '0;
		edge_n = -1;
		running = 1'b0;
		errs = 0;
		tests_run = 0;
		tests_failed = 0;

		// Zero outputs while reset is held and until data crosses the pipeline
		start_test("reset");
		#10;
		check_all_zero();
		@(posedge clk);
		@(negedge clk);
		check_all_zero();
		for (int i = 0; i < 10; i++) begin
			random_cycle(1'b1, 1'b0);
			@(negedge clk);
			#1;
			// Midpoint word looks one sample ahead, so it can move a cycle early
			if (edge_n < LAT_TOTAL - 1)
				check_all_zero();
		end
		end_test();

		start_test("in_phase");
		repeat (200) random_cycle(1'b1, 1'b0);
		end_test();

		start_test("quadrature");
		repeat (200) random_cycle(1'b1, 1'b0);
		end_test();

		start_test("flip");
		repeat (200) random_cycle(1'b1, 1'b1);
		end_test();

		// Zero from the 5th cycle after enable drops
		start_test("enable");
		for (int i = 0; i < 25; i++) begin
			random_cycle(1'b0, 1'b0);
			@(negedge clk);
			if (i >= 5)
				check_all_zero();
		end
		repeat (60) random_cycle(1'b1, 1'b0);
		end_test();

		start_test("coefficient");
		// Gain of one half makes the midpoint equal the direct word
		// Drive slice 10000 on both channels interpolates to 20000
		// In-phase (20000*60000 + 20000*20000) >>> 17 is 12207, doubled in the expander
		// Quadrature (-20001*60000 + 20000*20000) >>> 17 is -6104, doubled in the expander
		repeat (15) drive_cycle(1'b1, 1'b0, 18'sd40000, 18'sd60000, 18'sd20000, 16'd32768);
		@(negedge clk);
		check_value("dac1 out0 half gain", 24414, longint'(dac1_out0));
		check_value("dac1 out1 half gain", 24414, longint'(dac1_out1));
		check_value("dac2 out0 half gain", -12208, longint'(dac2_out0));
		check_value("dac2 out1 half gain", -12208, longint'(dac2_out1));
		// Full scale drive and LO clamp both words
		repeat (15) drive_cycle(1'b1, 1'b0, 18'sd131071, 18'sd131071, 18'sd131071, 16'hffff);
		@(negedge clk);
		check_value("dac1 out0 full scale", 32767, longint'(dac1_out0));
		check_value("dac1 out1 full scale", 32767, longint'(dac1_out1));
		repeat (70) random_cycle(1'b1, 1'b0);
		end_test();

		$display("Tests run %0d, tests failed %0d, mismatches %0d",
			tests_run, tests_failed, errs);
		if (errs == 0 && tests_failed == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+common
common/ssb_pkg.sv
hdl/fiq_interp.sv
hdl/flevel_set.sv
hdl/afterburner.sv
ssb_out/ssb_out.sv
test/ssb_out_properties.sv
test/ssb_out_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= ssb_out_tb
RTL_TOP   ?= ssb_out
FILELIST  ?= verilog.f
OBJDIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJDIR)
